/* verilog/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ******************************
// Datapath widths
// ******************************
`define XLEN        32              // Data and address width
`define REG_ADDR_W  5               // Register index width

// ******************************
// Fetch constants
// ******************************
`define RESET_PC    32'h0000_0000   // First fetch address
`define NOP_INSTR   32'h0000_0013   // addi x0,x0,0 bubble

// ******************************
// Opcodes of the supported subset
// ******************************
`define OPC_OP      7'b0110011      // Register-register ALU
`define OPC_OPIMM   7'b0010011      // Immediate ALU
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011      // LW only
`define OPC_STORE   7'b0100011      // SW only
`define OPC_BRANCH  7'b1100011      // BEQ and BNE

`endif

/* verilog/rvPkg.sv */
`default_nettype none
`include "rv_cfg.svh"

package rvPkg;

	// ALU function select
	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,            // Signed compare
		ALU_PASSB           // Operand B straight through for LUI
	} aluOpT;

	// Decoded control, all zero means no-op
	typedef struct packed
	{
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  branch;
		logic  branchNe;    // BNE when set, BEQ otherwise
		logic  useImm;      // Operand B from immediate
		aluOpT aluOp;
	} ctrlT;

	// ******************************
	// Pipeline registers
	// ******************************
	typedef struct packed
	{
		logic                   valid;
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       instr;
	} ifIdT;

	typedef struct packed
	{
		logic                   valid;
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       rs1Val;
		logic [`XLEN-1:0]       rs2Val;
		logic [`XLEN-1:0]       imm;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
		ctrlT                   ctrl;
	} idExT;

	typedef struct packed
	{
		logic                   valid;
		logic [`XLEN-1:0]       aluResult;  // Also the data address
		logic [`XLEN-1:0]       storeData;  // Forwarded rs2
		logic [`REG_ADDR_W-1:0] rd;
		logic                   regWrite;
		logic                   memRead;
		logic                   memWrite;
	} exMemT;

	// Valid only for a real register write to nonzero rd
	typedef struct packed
	{
		logic                   valid;
		logic [`XLEN-1:0]       result;
		logic [`REG_ADDR_W-1:0] rd;
	} memWbT;

endpackage

`default_nettype wire

/* verilog/bypassIf.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

// MEM and WB write information fed back to the earlier stages
interface bypassIf;

	// Instruction in MEM
	logic [`REG_ADDR_W-1:0] memRd;
	logic                   memRegWrite;
	logic [`XLEN-1:0]       memResult;      // ALU result held in EX/MEM

	// Instruction in WB
	logic [`REG_ADDR_W-1:0] wbRd;
	logic                   wbRegWrite;
	logic [`XLEN-1:0]       wbResult;       // Value going into the register file

	modport source (output memRd, memRegWrite, memResult, wbRd, wbRegWrite, wbResult);

	modport sink (input memRd, memRegWrite, memResult, wbRd, wbRegWrite, wbResult);

	// Register file write port only
	modport wbSink (input wbRd, wbRegWrite, wbResult);

endinterface

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module regFile
(
	input  logic                   iCLK,
	input  logic                   iRST,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	bypassIf.wbSink                bypass,     // Write port from WB
	output logic [`XLEN-1:0]       rs1Val,
	output logic [`XLEN-1:0]       rs2Val
);

	logic [`XLEN-1:0] regs [1:31];    // No storage for x0
	logic             wrEn;

	assign wrEn = bypass.wbRegWrite && (bypass.wbRd != '0);

	// Read with x0 tie-off and same-cycle write bypass
	function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wrEn && bypass.wbRd == addr)
			return bypass.wbResult;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
			regs[bypass.wbRd] <= bypass.wbResult;
	end

	always_comb
	begin
		rs1Val = readReg(rs1);
		rs2Val = readReg(rs2);
	end

endmodule

`default_nettype wire

/* verilog/fetchStage.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module fetchStage
	import rvPkg::*;
(
	input  logic             iCLK,
	input  logic             iRST,
	input  logic             stall,          // Load-use hold from decode
	input  logic             redirect,       // Taken branch in execute
	input  logic [`XLEN-1:0] redirectPc,
	input  logic [`XLEN-1:0] imemData,       // Combinational instruction read
	output logic [`XLEN-1:0] imemAddr,
	output ifIdT             ifId
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] nextPc;

	assign imemAddr = pc;

	// Next PC select, redirect wins
	always_comb
	begin
		if (redirect)
			nextPc = redirectPc;
		else if (stall)
			nextPc = pc;            // Hold
		else
			nextPc = pc + 4;
	end

	// ******************************
	// PC and IF/ID register
	// ******************************
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			pc         <= `RESET_PC;
			ifId.valid <= 1'b0;
			ifId.pc    <= '0;
			ifId.instr <= `NOP_INSTR;
		end
		else
		begin
			pc <= nextPc;
			if (redirect)
			begin
				ifId.valid <= 1'b0;        // Squash the wrong-path fetch
				ifId.pc    <= pc;
				ifId.instr <= `NOP_INSTR;
			end
			else if (!stall)
			begin
				ifId.valid <= 1'b1;
				ifId.pc    <= pc;
				ifId.instr <= imemData;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module decodeStage
	import rvPkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  ifIdT    ifId,
	input  logic    redirect,       // Squash from execute
	bypassIf.wbSink bypass,         // Register file write port
	output logic    stall,          // Load-use hold to fetch
	output idExT    idEx
);

	logic [`XLEN-1:0]       instr;
	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN-1:0]       immI;
	logic [`XLEN-1:0]       immS;
	logic [`XLEN-1:0]       immB;
	logic [`XLEN-1:0]       immU;
	logic [`XLEN-1:0]       imm;
	logic [`XLEN-1:0]       rs1Val;
	logic [`XLEN-1:0]       rs2Val;
	ctrlT                   ctrl;

	// Field split
	assign instr  = ifId.instr;
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	// Immediate formats, sign extended
	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};

	regFile regFile_inst
	(
		.iCLK   (iCLK),
		.iRST   (iRST),
		.rs1    (rs1),
		.rs2    (rs2),
		.bypass (bypass),
		.rs1Val (rs1Val),
		.rs2Val (rs2Val)
	);

	// ******************************
	// Control decode
	// ******************************
	always_comb
	begin
		ctrl = '0;                  // Unknown encodings stay a no-op
		imm  = immI;
		case (opcode)
			`OPC_OP, `OPC_OPIMM:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = (opcode == `OPC_OPIMM);
				case (funct3)
					3'b000: ctrl.aluOp = (opcode == `OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
					3'b010: ctrl.aluOp = ALU_SLT;
					3'b100: ctrl.aluOp = ALU_XOR;
					3'b110: ctrl.aluOp = ALU_OR;
					3'b111: ctrl.aluOp = ALU_AND;
					default: ctrl.regWrite = 1'b0;   // Shifts and SLTU
				endcase
				// R-type funct7 must be 0, or 0x20 for SUB
				if (opcode == `OPC_OP && funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 == 3'b000))
					ctrl.regWrite = 1'b0;
				if (!ctrl.regWrite)
					ctrl = '0;
			end
			`OPC_LUI:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.aluOp    = ALU_PASSB;
				imm           = immU;
			end
			`OPC_LOAD:
			begin
				ctrl.regWrite = (funct3 == 3'b010);    // LW only
				ctrl.memRead  = (funct3 == 3'b010);
				ctrl.useImm   = 1'b1;
			end
			`OPC_STORE:
			begin
				ctrl.memWrite = (funct3 == 3'b010);    // SW only
				ctrl.useImm   = 1'b1;
				imm           = immS;
			end
			`OPC_BRANCH:
			begin
				ctrl.branch   = (funct3 == 3'b000) || (funct3 == 3'b001);
				ctrl.branchNe = (funct3 == 3'b001);
				imm           = immB;
			end
			default: ctrl = '0;
		endcase
	end

	// Load in EX feeding the instruction in ID
	assign stall = idEx.valid && idEx.ctrl.memRead && (idEx.rd != '0) && ifId.valid &&
	               ((idEx.rd == rs1) || (idEx.rd == rs2));

	// ******************************
	// ID/EX register
	// ******************************
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
			idEx <= '0;
		else if (redirect || stall)
			idEx <= '0;             // Bubble
		else
		begin
			idEx.valid  <= ifId.valid;
			idEx.pc     <= ifId.pc;
			idEx.rs1Val <= rs1Val;
			idEx.rs2Val <= rs2Val;
			idEx.imm    <= imm;
			idEx.rs1    <= rs1;
			idEx.rs2    <= rs2;
			idEx.rd     <= rd;
			idEx.ctrl   <= ctrl;
		end
	end

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module executeStage
	import rvPkg::*;
(
	input  logic             iCLK,
	input  logic             iRST,
	input  idExT             idEx,
	bypassIf.sink            bypass,         // MEM and WB results for forwarding
	output logic             redirect,       // Taken branch
	output logic [`XLEN-1:0] redirectPc,
	output exMemT            exMem
);

	logic [`XLEN-1:0] opA;          // Forwarded rs1
	logic [`XLEN-1:0] fwdB;         // Forwarded rs2
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluResult;
	logic             operandsEq;

	// ******************************
	// Forwarding, MEM before WB
	// ******************************
	function automatic logic [`XLEN-1:0] forward(input logic [`REG_ADDR_W-1:0] rs,
	                                             input logic [`XLEN-1:0] regVal);
		if (bypass.memRegWrite && bypass.memRd != '0 && bypass.memRd == rs)
			return bypass.memResult;
		else if (bypass.wbRegWrite && bypass.wbRd != '0 && bypass.wbRd == rs)
			return bypass.wbResult;
		else
			return regVal;
	endfunction

	always_comb
	begin
		opA  = forward(idEx.rs1, idEx.rs1Val);
		fwdB = forward(idEx.rs2, idEx.rs2Val);
	end

	assign opB = idEx.ctrl.useImm ? idEx.imm : fwdB;

	// ALU
	always_comb
	begin
		case (idEx.ctrl.aluOp)
			ALU_ADD:   aluResult = opA + opB;
			ALU_SUB:   aluResult = opA - opB;
			ALU_AND:   aluResult = opA & opB;
			ALU_OR:    aluResult = opA | opB;
			ALU_XOR:   aluResult = opA ^ opB;
			ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			ALU_PASSB: aluResult = opB;     // LUI
			default:   aluResult = '0;
		endcase
	end

	// Branch resolve
	assign operandsEq = (opA == fwdB);
	assign redirect   = idEx.valid && idEx.ctrl.branch &&
	                    (idEx.ctrl.branchNe ? !operandsEq : operandsEq);
	assign redirectPc = idEx.pc + idEx.imm;

	// ******************************
	// EX/MEM register
	// ******************************
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
			exMem <= '0;
		else
		begin
			exMem.valid     <= idEx.valid;
			exMem.aluResult <= aluResult;
			exMem.storeData <= fwdB;        // SW data
			exMem.rd        <= idEx.rd;
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.memRead   <= idEx.ctrl.memRead;
			exMem.memWrite  <= idEx.ctrl.memWrite;
		end
	end

endmodule

`default_nettype wire

/* verilog/memoryStage.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module memoryStage
	import rvPkg::*;
(
	input  logic                   iCLK,
	input  logic                   iRST,
	input  exMemT                  exMem,
	input  logic [`XLEN-1:0]       dmemReadData,   // Combinational data read
	output logic                   dmemRead,
	output logic                   dmemWrite,
	output logic [`XLEN-1:0]       dmemAddr,
	output logic [`XLEN-1:0]       dmemWriteData,
	bypassIf.source                bypass,
	output logic                   commitValid,
	output logic [`REG_ADDR_W-1:0] commitRd,
	output logic [`XLEN-1:0]       commitData
);

	memWbT memWb;

	// ******************************
	// Data bus
	// ******************************
	assign dmemRead      = exMem.valid && exMem.memRead;
	assign dmemWrite     = exMem.valid && exMem.memWrite;
	assign dmemAddr      = exMem.aluResult;
	assign dmemWriteData = exMem.storeData;

	// MEM/WB register, result selected on the way in
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
			memWb <= '0;
		else
		begin
			memWb.valid  <= exMem.valid && exMem.regWrite && (exMem.rd != '0);
			memWb.result <= exMem.memRead ? dmemReadData : exMem.aluResult;
			memWb.rd     <= exMem.rd;
		end
	end

	// ******************************
	// Feedback to EX and ID
	// ******************************
	assign bypass.memRd       = exMem.rd;
	assign bypass.memRegWrite = exMem.valid && exMem.regWrite;
	assign bypass.memResult   = exMem.aluResult;
	assign bypass.wbRd        = memWb.rd;
	assign bypass.wbRegWrite  = memWb.valid;
	assign bypass.wbResult    = memWb.result;

	// Commit port mirrors the register file write
	assign commitValid = memWb.valid;
	assign commitRd    = memWb.rd;
	assign commitData  = memWb.result;

endmodule

`default_nettype wire

/* verilog/rvPipeline.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvPipeline
	import rvPkg::*;
(
	input  logic                   iCLK,
	input  logic                   iRST,
	// Instruction bus
	output logic [`XLEN-1:0]       imemAddr,
	input  logic [`XLEN-1:0]       imemData,
	// Data bus
	output logic [`XLEN-1:0]       dmemAddr,
	output logic [`XLEN-1:0]       dmemWriteData,
	output logic                   dmemRead,
	output logic                   dmemWrite,
	input  logic [`XLEN-1:0]       dmemReadData,
	// Retired register writes
	output logic                   commitValid,
	output logic [`REG_ADDR_W-1:0] commitRd,
	output logic [`XLEN-1:0]       commitData
);

	ifIdT             ifId;
	idExT             idEx;
	exMemT            exMem;
	logic             stall;        // Load-use
	logic             redirect;     // Taken branch
	logic [`XLEN-1:0] redirectPc;

	bypassIf bypass ();

	fetchStage fetchStage_inst
	(
		.iCLK       (iCLK),
		.iRST       (iRST),
		.stall      (stall),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.imemData   (imemData),
		.imemAddr   (imemAddr),
		.ifId       (ifId)
	);

	decodeStage decodeStage_inst
	(
		.iCLK     (iCLK),
		.iRST     (iRST),
		.ifId     (ifId),
		.redirect (redirect),
		.bypass   (bypass.wbSink),
		.stall    (stall),
		.idEx     (idEx)
	);

	executeStage executeStage_inst
	(
		.iCLK       (iCLK),
		.iRST       (iRST),
		.idEx       (idEx),
		.bypass     (bypass.sink),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.exMem      (exMem)
	);

	memoryStage memoryStage_inst
	(
		.iCLK          (iCLK),
		.iRST          (iRST),
		.exMem         (exMem),
		.dmemReadData  (dmemReadData),
		.dmemRead      (dmemRead),
		.dmemWrite     (dmemWrite),
		.dmemAddr      (dmemAddr),
		.dmemWriteData (dmemWriteData),
		.bypass        (bypass.source),
		.commitValid   (commitValid),
		.commitRd      (commitRd),
		.commitData    (commitData)
	);

endmodule

`default_nettype wire

/* sim/rvPipeline_properties.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvPipeline_properties
(
	input logic                   iCLK,
	input logic                   iRST,
	input logic [`XLEN-1:0]       imemAddr,
	input logic                   dmemRead,
	input logic                   dmemWrite,
	input logic                   commitValid,
	input logic [`REG_ADDR_W-1:0] commitRd
);

	// ******************************
	// Bus and commit rules
	// ******************************
	noReadAndWrite: assert property (@(posedge iCLK) disable iff (iRST)
		!(dmemRead && dmemWrite))
		else $error("Data bus read and write high in the same cycle");

	commitNonzeroRd: assert property (@(posedge iCLK) disable iff (iRST)
		commitValid |-> (commitRd != '0))       // x0 never retires
		else $error("Commit reported for register x0");

	fetchAligned: assert property (@(posedge iCLK) disable iff (iRST)
		imemAddr[1:0] == 2'b00)
		else $error("Instruction address not word aligned");

	// First sampled cycle after reset release
	idleAfterReset: assert property (@(posedge iCLK)
		$fell(iRST) |-> (!commitValid && !dmemRead && !dmemWrite && imemAddr == `RESET_PC))
		else $error("Outputs not idle right after reset");

endmodule

bind rvPipeline rvPipeline_properties rvPipeline_properties_inst
(
	.iCLK        (iCLK),
	.iRST        (iRST),
	.imemAddr    (imemAddr),
	.dmemRead    (dmemRead),
	.dmemWrite   (dmemWrite),
	.commitValid (commitValid),
	.commitRd    (commitRd)
);

`default_nettype wire

/* sim/rvPipeline_tb.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvPipeline_tb;

	localparam int HALF_PERIOD     = 20;
	localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
	localparam int RESET_CYCLES    = 8;
	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 200;
	localparam int SEED            = 55691;

	logic                   iCLK = 1'b0;
	logic                   iRST = 1'b1;
	logic [`XLEN-1:0]       imemAddr;
	logic [`XLEN-1:0]       imemData;
	logic [`XLEN-1:0]       dmemAddr;
	logic [`XLEN-1:0]       dmemWriteData;
	logic                   dmemRead;
	logic                   dmemWrite;
	logic [`XLEN-1:0]       dmemReadData;
	logic                   commitValid;
	logic [`REG_ADDR_W-1:0] commitRd;
	logic [`XLEN-1:0]       commitData;

	logic [`XLEN-1:0]       imem [0:255];
	logic [`XLEN-1:0]       dmem [0:255];
	logic [`XLEN-1:0]       prog [$];       // Program under test
	logic [`REG_ADDR_W-1:0] expRd [$];
	logic [`XLEN-1:0]       expData [$];
	logic [`REG_ADDR_W-1:0] gotRd [$];      // Observed commit stream
	logic [`XLEN-1:0]       gotData [$];
	logic [`XLEN-1:0]       storeAddrs [$];
	logic [`XLEN-1:0]       storeDatas [$];
	logic [`XLEN-1:0]       loadAddrs [$];  // Addresses seen with dmemRead high
	bit                     markerSeen;
	int                     errorCount = 0;
	int                     checkCount = 0;

	rvPipeline rvPipeline_inst
	(
		.iCLK          (iCLK),
		.iRST          (iRST),
		.imemAddr      (imemAddr),
		.imemData      (imemData),
		.dmemAddr      (dmemAddr),
		.dmemWriteData (dmemWriteData),
		.dmemRead      (dmemRead),
		.dmemWrite     (dmemWrite),
		.dmemReadData  (dmemReadData),
		.commitValid   (commitValid),
		.commitRd      (commitRd),
		.commitData    (commitData)
	);

	always #HALF_PERIOD iCLK = ~iCLK;

	// Combinational memories
	assign imemData     = imem[imemAddr[9:2]];
	assign dmemReadData = dmem[dmemAddr[9:2]];

	// ******************************
	// Bus monitor and data memory
	// ******************************
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			gotRd.delete();
			gotData.delete();
			storeAddrs.delete();
			storeDatas.delete();
			loadAddrs.delete();
			markerSeen = 1'b0;
			for (int i = 0; i < 256; i++)
				dmem[8'(i)] = 32'hDA7A_0000 ^ 32'(i * 4);   // Address dependent fill
		end
		else
		begin
			if (commitValid)
			begin
				gotRd.push_back(commitRd);
				gotData.push_back(commitData);
				if (commitRd == 5'd31)
					markerSeen = 1'b1;          // Marker is the last commit
			end
			if (dmemRead)
				loadAddrs.push_back(dmemAddr);
			if (dmemWrite)
			begin
				storeAddrs.push_back(dmemAddr);
				storeDatas.push_back(dmemWriteData);
				dmem[dmemAddr[9:2]] = dmemWriteData;
			end
		end
	end

	// Instruction formats
	function automatic logic [31:0] rTypeInstr(input logic [6:0] f7, input logic [4:0] rs2,
	                                           input logic [4:0] rs1, input logic [2:0] f3,
	                                           input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [31:0] iTypeInstr(input logic [11:0] imm, input logic [4:0] rs1,
	                                           input logic [2:0] f3, input logic [4:0] rd,
	                                           input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sTypeInstr(input logic [11:0] imm, input logic [4:0] rs2,
	                                           input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};    // SW
	endfunction

	function automatic logic [31:0] bTypeInstr(input logic [12:0] imm, input logic [4:0] rs2,
	                                           input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] luiInstr(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, `OPC_LUI};
	endfunction

	function automatic logic [31:0] signExtend12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	// LUI part that pairs with an ADDI of the low 12 bits
	function automatic logic [19:0] upperImm(input logic [31:0] value);
		return 20'((value + 32'h800) >> 12);
	endfunction

	function automatic void emit(input logic [31:0] instr);
		prog.push_back(instr);
	endfunction

	function automatic void expectCommit(input logic [4:0] rd, input logic [31:0] data);
		expRd.push_back(rd);
		expData.push_back(data);
	endfunction

	task automatic checkValue(input string testName, input string what,
	                          input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("error %s: %s expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkIdle(input string testName, input string phase);
		checkValue(testName, {phase, " commitValid"}, 32'd0, 32'(commitValid));
		checkValue(testName, {phase, " dmemRead"}, 32'd0, 32'(dmemRead));
		checkValue(testName, {phase, " dmemWrite"}, 32'd0, 32'(dmemWrite));
		checkValue(testName, {phase, " imemAddr"}, `RESET_PC, imemAddr);
	endtask

	// Program image with addi x0,x0,addr in the unused words
	task automatic loadImem();
		for (int i = 0; i < 256; i++)
		begin
			if (i < prog.size())
				imem[8'(i)] = prog[i];
			else
				imem[8'(i)] = iTypeInstr(12'(i * 4), 5'd0, 3'b000, 5'd0, `OPC_OPIMM);
		end
	endtask

	task automatic compareCommits(input string testName);
		checkCount++;
		assert (gotRd.size() == expRd.size())
		else
		begin
			errorCount++;
			$display("error %s: commit count expected %0d, actual %0d", testName,
			         expRd.size(), gotRd.size());
		end
		for (int i = 0; i < expRd.size() && i < gotRd.size(); i++)
		begin
			checkValue(testName, $sformatf("commit %0d rd", i), 32'(expRd[i]), 32'(gotRd[i]));
			checkValue(testName, $sformatf("commit %0d data", i), expData[i], gotData[i]);
		end
	endtask

	// ******************************
	// Reset, run to marker, compare
	// ******************************
	task automatic runProgram(input string testName);
		int waited;
		emit(iTypeInstr(12'hFFF, 5'd0, 3'b000, 5'd31, `OPC_OPIMM));   // Marker addi x31,x0,-1
		expectCommit(5'd31, 32'hFFFF_FFFF);
		@(posedge iCLK);
		iRST <= 1'b1;
		loadImem();
		repeat (RESET_CYCLES) @(posedge iCLK);
		iRST <= 1'b0;
		waited = 0;
		while (!markerSeen && waited < CYCLES_PER_TEST)
		begin
			@(posedge iCLK);
			waited++;
		end
		checkCount++;
		assert (markerSeen)
		else
		begin
			errorCount++;
			$display("%s: the marker instruction did not commit in %0d cycles", testName,
			         CYCLES_PER_TEST);
		end
		compareCommits(testName);
		prog.delete();
		expRd.delete();
		expData.delete();
	endtask

	task automatic checkResetState();
		@(posedge iCLK);
		iRST <= 1'b1;
		repeat (RESET_CYCLES)
		begin
			@(negedge iCLK);
			checkIdle("reset", "in reset");
		end
		@(posedge iCLK);
		iRST <= 1'b0;
		@(negedge iCLK);
		checkIdle("reset", "after reset");
	endtask

	// Back-to-back dependent ALU chain
	task automatic aluForwardingChain();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r [3:13];
		logic [11:0] imm [9:13];
		a = $urandom;
		b = $urandom;
		for (int i = 9; i <= 13; i++)
			imm[i] = 12'($urandom);
		r[3]  = a + b;
		r[4]  = r[3] - a;
		r[5]  = r[4] & r[3];
		r[6]  = r[5] | b;
		r[7]  = r[6] ^ r[4];
		r[8]  = ($signed(r[7]) < $signed(a)) ? 32'd1 : 32'd0;
		r[9]  = r[8] + signExtend12(imm[9]);
		r[10] = r[9] & signExtend12(imm[10]);
		r[11] = r[10] | signExtend12(imm[11]);
		r[12] = r[11] ^ signExtend12(imm[12]);
		r[13] = ($signed(r[12]) < $signed(signExtend12(imm[13]))) ? 32'd1 : 32'd0;
		emit(luiInstr(upperImm(a), 5'd1));
		expectCommit(5'd1, {upperImm(a), 12'h000});
		emit(iTypeInstr(a[11:0], 5'd1, 3'b000, 5'd1, `OPC_OPIMM));
		expectCommit(5'd1, a);
		emit(luiInstr(upperImm(b), 5'd2));
		expectCommit(5'd2, {upperImm(b), 12'h000});
		emit(iTypeInstr(b[11:0], 5'd2, 3'b000, 5'd2, `OPC_OPIMM));
		expectCommit(5'd2, b);
		emit(rTypeInstr(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));     // add
		emit(rTypeInstr(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));     // sub
		emit(rTypeInstr(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));     // and
		emit(rTypeInstr(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));     // or
		emit(rTypeInstr(7'h00, 5'd4, 5'd6, 3'b100, 5'd7));     // xor
		emit(rTypeInstr(7'h00, 5'd1, 5'd7, 3'b010, 5'd8));     // slt
		emit(iTypeInstr(imm[9], 5'd8, 3'b000, 5'd9, `OPC_OPIMM));
		emit(iTypeInstr(imm[10], 5'd9, 3'b111, 5'd10, `OPC_OPIMM));
		emit(iTypeInstr(imm[11], 5'd10, 3'b110, 5'd11, `OPC_OPIMM));
		emit(iTypeInstr(imm[12], 5'd11, 3'b100, 5'd12, `OPC_OPIMM));
		emit(iTypeInstr(imm[13], 5'd12, 3'b010, 5'd13, `OPC_OPIMM));
		for (int i = 3; i <= 13; i++)
			expectCommit(5'(i), r[i]);
		runProgram("alu forwarding");
	endtask

	// SW, LW of the same word, then an immediate consumer
	task automatic storeThenLoadUse();
		logic [31:0] value;
		logic [11:0] immC;
		value = $urandom;
		immC  = 12'($urandom);
		emit(iTypeInstr(12'h040, 5'd0, 3'b000, 5'd1, `OPC_OPIMM));
		expectCommit(5'd1, 32'h0000_0040);
		emit(luiInstr(upperImm(value), 5'd2));
		expectCommit(5'd2, {upperImm(value), 12'h000});
		emit(iTypeInstr(value[11:0], 5'd2, 3'b000, 5'd2, `OPC_OPIMM));
		expectCommit(5'd2, value);
		emit(sTypeInstr(12'h008, 5'd2, 5'd1));                    // sw x2,8(x1)
		emit(iTypeInstr(12'h008, 5'd1, 3'b010, 5'd3, `OPC_LOAD));   // lw x3,8(x1)
		expectCommit(5'd3, value);
		emit(iTypeInstr(immC, 5'd3, 3'b000, 5'd4, `OPC_OPIMM));     // Load-use bubble
		expectCommit(5'd4, value + signExtend12(immC));
		runProgram("store load-use");
		checkValue("store load-use", "store count", 32'd1, 32'(storeAddrs.size()));
		if (storeAddrs.size() > 0)
		begin
			checkValue("store load-use", "store address", 32'h0000_0048, storeAddrs[0]);
			checkValue("store load-use", "store data", value, storeDatas[0]);
		end
		checkValue("store load-use", "load count", 32'd1, 32'(loadAddrs.size()));
		if (loadAddrs.size() > 0)
			checkValue("store load-use", "load address", 32'h0000_0048, loadAddrs[0]);
	endtask

	// Taken BEQ, taken BNE, not-taken BEQ
	task automatic branchSkips();
		logic [11:0] v;
		v = 12'($urandom) & 12'h7FF;
		emit(iTypeInstr(v, 5'd0, 3'b000, 5'd1, `OPC_OPIMM));
		emit(iTypeInstr(v, 5'd0, 3'b000, 5'd2, `OPC_OPIMM));
		emit(bTypeInstr(13'd12, 5'd2, 5'd1, 3'b000));             // beq x1,x2 taken
		emit(iTypeInstr(12'd1, 5'd0, 3'b000, 5'd3, `OPC_OPIMM));   // Skipped
		emit(iTypeInstr(12'd2, 5'd0, 3'b000, 5'd4, `OPC_OPIMM));   // Skipped
		emit(iTypeInstr(v ^ 12'h001, 5'd0, 3'b000, 5'd5, `OPC_OPIMM));
		emit(bTypeInstr(13'd12, 5'd5, 5'd1, 3'b001));             // bne x1,x5 taken
		emit(iTypeInstr(12'd4, 5'd0, 3'b000, 5'd6, `OPC_OPIMM));
		emit(iTypeInstr(12'd5, 5'd0, 3'b000, 5'd7, `OPC_OPIMM));
		emit(bTypeInstr(13'd12, 5'd5, 5'd1, 3'b000));             // Falls through
		emit(iTypeInstr(12'd6, 5'd0, 3'b000, 5'd8, `OPC_OPIMM));
		emit(iTypeInstr(12'd7, 5'd0, 3'b000, 5'd9, `OPC_OPIMM));
		expectCommit(5'd1, signExtend12(v));
		expectCommit(5'd2, signExtend12(v));
		expectCommit(5'd5, signExtend12(v ^ 12'h001));
		expectCommit(5'd8, 32'd6);
		expectCommit(5'd9, 32'd7);
		runProgram("branches");
	endtask

	task automatic zeroRegisterWrites();
		logic [11:0] k1;
		logic [11:0] k3;
		k1 = 12'($urandom);
		k3 = 12'($urandom);
		emit(iTypeInstr(k1, 5'd0, 3'b000, 5'd1, `OPC_OPIMM));
		emit(iTypeInstr(12'($urandom), 5'd1, 3'b000, 5'd0, `OPC_OPIMM));  // No commit
		emit(rTypeInstr(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));                // x0 must read 0
		emit(luiInstr(20'($urandom), 5'd0));
		emit(iTypeInstr(k3, 5'd0, 3'b000, 5'd3, `OPC_OPIMM));
		expectCommit(5'd1, signExtend12(k1));
		expectCommit(5'd2, signExtend12(k1));
		expectCommit(5'd3, signExtend12(k3));
		runProgram("x0 writes");
	endtask

	// ******************************
	// Test sequence and watchdog
	// ******************************
	initial
	begin
		void'($urandom(SEED));
		loadImem();                     // Empty program, all no-ops
		checkResetState();
		aluForwardingChain();
		storeThenLoadUse();
		branchSkips();
		zeroRegisterWrites();
		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/rvPkg.sv
verilog/bypassIf.sv
verilog/regFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/rvPipeline.sv
sim/rvPipeline_properties.sv
sim/rvPipeline_tb.sv

/* Makefile */
TOP = rvPipeline_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

# Pass or fail comes from the printed verdict line
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
